// File: frontend_consts.svh
// Compile-time sizes only; IMSS_SIZE_BYTES must be a power of two and DECODE_QUEUE_DEPTH at least 2
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Instruction memory size in bytes
`define IMSS_SIZE_BYTES 1024

// Request to response latency in cycles, fixed by the stub pipeline
`define IMSS_LATENCY 2

// Decode queue entries, also the fetch credit count
`define DECODE_QUEUE_DEPTH 4

`endif

// File: riscv_pkg.sv
// RV32I base encodings only; no compressed, CSR or extension formats
package riscv_pkg;

    typedef logic [31:0] word_t;

    // Major opcodes of RV32I
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_OP       = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    // FMT_ILLEGAL marks a fetch fault, FMT_BAD an unknown opcode
    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_BAD, FMT_ILLEGAL
    } inst_fmt_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_s;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_s;

    // Branch offset bits are scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_s;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_s;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_s;

    // One instruction word, six field views
    typedef union packed {
        word_t   raw;
        r_type_s r;
        i_type_s i;
        s_type_s s;
        b_type_s b;
        u_type_s u;
        j_type_s j;
    } inst_u;

endpackage

// File: frontend_pkg.sv
// Front-end types sized from frontend_consts.svh; relies on riscv_pkg for the format enum
package frontend_pkg;

    `include "frontend_consts.svh"

    import riscv_pkg::*;

    // Byte address, no translation
    typedef logic [`XLEN-1:0] addr_t;

    // Counter holding 0 up to DECODE_QUEUE_DEPTH inclusive
    typedef logic [$clog2(`DECODE_QUEUE_DEPTH + 1)-1:0] qptr_t;

    // One decoded instruction as seen at the queue head
    typedef struct packed {
        addr_t     pc;
        inst_fmt_e fmt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t     imm;
    } decoded_s;

endpackage

// File: imss_if.sv
// No response ready; the consumer must always accept a response
`timescale 1ns/1ps

interface imss_if
    import riscv_pkg::*, frontend_pkg::*;
();

    // Request side, from fetch
    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;

    // Response side, from the memory subsystem
    logic  rsp_valid;
    logic  rsp_illegal;
    addr_t rsp_addr;
    word_t rsp_data;

    modport fetch (
        output req_valid,
        output req_addr,
        input  req_ready
    );

    modport subsystem (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_illegal,
        output rsp_addr,
        output rsp_data
    );

    // Decode only watches responses
    modport decode (
        input rsp_valid,
        input rsp_illegal,
        input rsp_addr,
        input rsp_data
    );

endinterface

// File: fetch_pc_gen.sv
// PC only increments by 4, no redirect; halt wins over start in the same cycle
`timescale 1ns/1ps

`include "frontend_consts.svh"

module fetch_pc_gen
    import frontend_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  addr_t start_pc,
    input  logic  halt,
    input  logic  slot_free,
    imss_if.fetch imss
);

    logic  running;
    addr_t pc;
    qptr_t credits;
    logic  req_fire;

    // Hold off while every queue slot is spoken for
    assign imss.req_valid = running && (credits != qptr_t'(`DECODE_QUEUE_DEPTH));
    assign imss.req_addr  = pc;
    assign req_fire       = imss.req_valid && imss.req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            credits <= '0;
        end else begin
            if (halt) begin
                running <= 1'b0;
            end else if (start) begin
                running <= 1'b1;
            end
            // Issued minus freed
            case ({req_fire, slot_free})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // PC moves only on an accepted request
    always_ff @(posedge clk) begin
        if (start) begin
            pc <= start_pc;
        end else if (req_fire) begin
            pc <= pc + addr_t'(4);
        end
    end

    // Decode frees slots only for items fetch paid for
    credit_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= qptr_t'(`DECODE_QUEUE_DEPTH));

endmodule

// File: imss_stub.sv
// Loads must be word aligned and not overlap a fetch to the same word; no reset on contents
`timescale 1ns/1ps

`include "frontend_consts.svh"

module imss_stub
    import riscv_pkg::*, frontend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_en,
    input  addr_t     load_addr,
    input  word_t     load_data,
    imss_if.subsystem imss
);

    localparam int IDX_W = $clog2(`IMSS_SIZE_BYTES);

    logic [7:0] mem [`IMSS_SIZE_BYTES];

    logic [IDX_W-1:0] load_base;
    logic [IDX_W-1:0] req_base;
    logic             req_illegal;
    word_t            req_data;

    // First pipeline stage
    logic  s1_valid;
    logic  s1_illegal;
    addr_t s1_addr;
    word_t s1_data;

    assign imss.req_ready = 1'b1;

    // Word base index, low bits forced so reads stay inside the array
    assign load_base = {load_addr[IDX_W-1:2], 2'b00};
    assign req_base  = {imss.req_addr[IDX_W-1:2], 2'b00};

    // Misaligned, or last byte past the end
    assign req_illegal = (imss.req_addr[1:0] != 2'b00) ||
                         (imss.req_addr > addr_t'(`IMSS_SIZE_BYTES - 4));

    // Little-endian word, zero on a fault
    assign req_data = req_illegal ? '0 :
        {mem[req_base + 3], mem[req_base + 2], mem[req_base + 1], mem[req_base]};

    // Out of range loads are ignored
    always_ff @(posedge clk) begin
        if (load_en && (load_addr <= addr_t'(`IMSS_SIZE_BYTES - 4))) begin
            for (int b = 0; b < 4; b++) begin
                mem[load_base + b] <= load_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid       <= 1'b0;
            imss.rsp_valid <= 1'b0;
        end else begin
            s1_valid       <= imss.req_valid && imss.req_ready;
            imss.rsp_valid <= s1_valid;
        end
    end

    // Payload follows valid, no reset
    always_ff @(posedge clk) begin
        s1_illegal       <= req_illegal;
        s1_addr          <= imss.req_addr;
        s1_data          <= req_data;
        imss.rsp_illegal <= s1_illegal;
        imss.rsp_addr    <= s1_addr;
        imss.rsp_data    <= s1_data;
    end

    load_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> (load_addr[1:0] == 2'b00));

endmodule

// File: inst_decode.sv
// Responses are taken unconditionally; fetch credits must keep the queue from overflowing
`timescale 1ns/1ps

`include "frontend_consts.svh"

module inst_decode
    import riscv_pkg::*, frontend_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    imss_if.decode   imss,
    output logic     slot_free,
    output logic     inst_valid,
    input  logic     inst_ready,
    output decoded_s inst
);

    localparam int DEPTH = `DECODE_QUEUE_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Queue storage
    addr_t q_pc   [DEPTH];
    logic  q_ill  [DEPTH];
    word_t q_word [DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    qptr_t            count;
    logic             push;
    logic             pop;
    inst_u            head;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign push       = imss.rsp_valid;
    assign inst_valid = (count != '0);
    assign pop        = inst_valid && inst_ready;
    // One credit back to fetch per departure
    assign slot_free  = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_idx]   <= imss.rsp_addr;
            q_ill[wr_idx]  <= imss.rsp_illegal;
            q_word[wr_idx] <= imss.rsp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (pop) begin
                rd_idx <= next_idx(rd_idx);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = q_word[rd_idx];

    // Head decode, missing fields stay zero
    always_comb begin
        inst     = '0;
        inst.pc  = q_pc[rd_idx];
        inst.fmt = FMT_BAD;
        if (q_ill[rd_idx]) begin
            inst.fmt = FMT_ILLEGAL;
        end else begin
            case (head.r.opcode)
                OP_OP: begin
                    inst.fmt = FMT_R;
                    inst.rd  = head.r.rd;
                    inst.rs1 = head.r.rs1;
                    inst.rs2 = head.r.rs2;
                end
                OP_IMM, OP_LOAD, OP_JALR, OP_MISC_MEM, OP_SYSTEM: begin
                    inst.fmt = FMT_I;
                    inst.rd  = head.i.rd;
                    inst.rs1 = head.i.rs1;
                    inst.imm = {{20{head.i.imm[11]}}, head.i.imm};
                end
                OP_STORE: begin
                    inst.fmt = FMT_S;
                    inst.rs1 = head.s.rs1;
                    inst.rs2 = head.s.rs2;
                    inst.imm = {{20{head.s.imm_11_5[6]}}, head.s.imm_11_5, head.s.imm_4_0};
                end
                OP_BRANCH: begin
                    inst.fmt = FMT_B;
                    inst.rs1 = head.b.rs1;
                    inst.rs2 = head.b.rs2;
                    // Halfword offset, bit 0 clear
                    inst.imm = {{19{head.b.imm_12}}, head.b.imm_12, head.b.imm_11,
                                head.b.imm_10_5, head.b.imm_4_1, 1'b0};
                end
                OP_LUI, OP_AUIPC: begin
                    inst.fmt = FMT_U;
                    inst.rd  = head.u.rd;
                    inst.imm = {head.u.imm_31_12, 12'b0};
                end
                OP_JAL: begin
                    inst.fmt = FMT_J;
                    inst.rd  = head.j.rd;
                    inst.imm = {{11{head.j.imm_20}}, head.j.imm_20, head.j.imm_19_12,
                                head.j.imm_11, head.j.imm_10_1, 1'b0};
                end
                default: inst.fmt = FMT_BAD;
            endcase
        end
    end

    // Full queue on a response means the fetch credit count is broken
    no_push_when_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < qptr_t'(DEPTH)));

endmodule

// File: frontend_top.sv
// Load only while halted; inst fields are stable while inst_valid waits for inst_ready
`timescale 1ns/1ps

module frontend_top
    import riscv_pkg::*, frontend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Word load port, little-endian
    input  logic      load_en,
    input  addr_t     load_addr,
    input  word_t     load_data,
    input  logic      start,
    input  addr_t     start_pc,
    input  logic      halt,
    // Decoded instruction stream
    output logic      inst_valid,
    input  logic      inst_ready,
    output addr_t     inst_pc,
    output inst_fmt_e inst_fmt,
    output logic [4:0] inst_rd,
    output logic [4:0] inst_rs1,
    output logic [4:0] inst_rs2,
    output word_t     inst_imm
);

    imss_if imss ();

    logic     slot_free;
    decoded_s inst;

    fetch_pc_gen u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .start_pc  (start_pc),
        .halt      (halt),
        .slot_free (slot_free),
        .imss      (imss.fetch)
    );

    imss_stub u_imss (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .imss      (imss.subsystem)
    );

    inst_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .imss       (imss.decode),
        .slot_free  (slot_free),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst)
    );

    // Flatten the decoded struct
    assign inst_pc  = inst.pc;
    assign inst_fmt = inst.fmt;
    assign inst_rd  = inst.rd;
    assign inst_rs1 = inst.rs1;
    assign inst_rs2 = inst.rs2;
    assign inst_imm = inst.imm;

endmodule

// File: tb_clkgen.sv
// Free-running 20 ns clock; reset is held low for 5 rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam time HALF_PERIOD = 10ns;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // Release away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: frontend_tb.sv
// Drives inputs on falling edges and samples there; assumes a 1024-byte memory and a 4-entry queue
`timescale 1ns/1ps

`include "frontend_consts.svh"

module frontend_tb
    import riscv_pkg::*, frontend_pkg::*;
();

    localparam int    TIMEOUT_CYCLES = 100;
    localparam int    DRAIN_IDLE     = 6;
    localparam addr_t LAST_WORD      = addr_t'(`IMSS_SIZE_BYTES - 4);

    // One stimulus row and its expected decode
    typedef struct packed {
        word_t      word;
        inst_fmt_e  fmt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t      imm;
    } row_s;

    logic       clk;
    logic       rst_n;
    logic       load_en;
    addr_t      load_addr;
    word_t      load_data;
    logic       start;
    addr_t      start_pc;
    logic       halt;
    logic       inst_valid;
    logic       inst_ready;
    addr_t      inst_pc;
    inst_fmt_e  inst_fmt;
    logic [4:0] inst_rd;
    logic [4:0] inst_rs1;
    logic [4:0] inst_rs2;
    word_t      inst_imm;

    row_s        rows[$];
    row_s        illegal_row;
    int          value_errors;
    int          timeout_errors;
    logic [31:0] lcg_state;

    tb_clkgen clkgen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    frontend_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .start      (start),
        .start_pc   (start_pc),
        .halt       (halt),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pc    (inst_pc),
        .inst_fmt   (inst_fmt),
        .inst_rd    (inst_rd),
        .inst_rs1   (inst_rs1),
        .inst_rs2   (inst_rs2),
        .inst_imm   (inst_imm)
    );

    // LCG step, one mid bit for back-pressure
    function automatic logic rand_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];
    endfunction

    task automatic check_fmt(input string what, input inst_fmt_e got, input inst_fmt_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s fmt got %s expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got x%0d expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input word_t word, input inst_fmt_e fmt, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2, input word_t imm);
        rows.push_back(row_s'{word, fmt, rd, rs1, rs2, imm});
    endtask

    task automatic load_word(input addr_t addr, input word_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    // Halt must be low, or it wins over start
    task automatic start_fetch(input addr_t pc);
        @(negedge clk);
        halt     = 1'b0;
        start_pc = pc;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Returns at the falling edge before the transfer edge, fields still stable
    task automatic take_inst(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            inst_ready = rand_bit();
            ok         = inst_valid && inst_ready;
        end
        if (!ok) begin
            timeout_errors++;
            $display("Timeout: no instruction was taken within %0d cycles at %0t",
                     TIMEOUT_CYCLES, $time);
        end
    endtask

    task automatic verify_inst(input row_s exp, input addr_t pc, input string what);
        check_addr({what, " pc"}, inst_pc, pc);
        check_fmt(what, inst_fmt, exp.fmt);
        check_reg({what, " rd"}, inst_rd, exp.rd);
        check_reg({what, " rs1"}, inst_rs1, exp.rs1);
        check_reg({what, " rs2"}, inst_rs2, exp.rs2);
        check_word({what, " imm"}, inst_imm, exp.imm);
    endtask

    task automatic expect_idle(input int cycles, input string when);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (inst_valid !== 1'b0) begin
                value_errors++;
                $display("FAILED at %0t: inst_valid high %s", $time, when);
            end
        end
    endtask

    // Halt, then pop until the output has been quiet for a while
    task automatic stop_and_drain();
        int idle;
        int cycles;
        idle   = 0;
        cycles = 0;
        @(negedge clk);
        halt       = 1'b1;
        inst_ready = 1'b1;
        while (idle < DRAIN_IDLE && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            idle = inst_valid ? 0 : idle + 1;
        end
        if (idle < DRAIN_IDLE) begin
            timeout_errors++;
            $display("Timeout: instruction output did not drain after halt at %0t", $time);
        end
    endtask

    initial begin
        inst_u w;
        logic  ok;
        int    cycles;
        value_errors   = 0;
        timeout_errors = 0;
        lcg_state      = 32'd60811;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        start          = 1'b0;
        start_pc       = '0;
        halt           = 1'b1;
        inst_ready     = 1'b0;
        illegal_row    = '{32'h0, FMT_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'h0};

        // Words built field by field, expected imm worked out by hand
        w.r = '{7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_OP};
        add_row(w.raw, FMT_R, 5'd3, 5'd1, 5'd2, 32'h0000_0000);
        w.i = '{12'hFFF, 5'd6, 3'd0, 5'd5, OP_IMM};
        add_row(w.raw, FMT_I, 5'd5, 5'd6, 5'd0, 32'hFFFF_FFFF);
        w.i = '{12'h7FF, 5'd8, 3'd2, 5'd7, OP_LOAD};
        add_row(w.raw, FMT_I, 5'd7, 5'd8, 5'd0, 32'h0000_07FF);
        // Store offset -8
        w.s = '{7'h7F, 5'd9, 5'd10, 3'd2, 5'h18, OP_STORE};
        add_row(w.raw, FMT_S, 5'd0, 5'd10, 5'd9, 32'hFFFF_FFF8);
        // Branch -2, every offset bit set
        w.b = '{1'b1, 6'h3F, 5'd12, 5'd11, 3'd0, 4'hF, 1'b1, OP_BRANCH};
        add_row(w.raw, FMT_B, 5'd0, 5'd11, 5'd12, 32'hFFFF_FFFE);
        // Only the displaced bit 11
        w.b = '{1'b0, 6'h00, 5'd14, 5'd13, 3'd1, 4'h0, 1'b1, OP_BRANCH};
        add_row(w.raw, FMT_B, 5'd0, 5'd13, 5'd14, 32'h0000_0800);
        w.u = '{20'hABCDE, 5'd15, OP_LUI};
        add_row(w.raw, FMT_U, 5'd15, 5'd0, 5'd0, 32'hABCD_E000);
        w.j = '{1'b0, 10'h155, 1'b1, 8'h12, 5'd1, OP_JAL};
        add_row(w.raw, FMT_J, 5'd1, 5'd0, 5'd0, 32'h0001_2AAA);
        w.j = '{1'b1, 10'h000, 1'b0, 8'h00, 5'd31, OP_JAL};
        add_row(w.raw, FMT_J, 5'd31, 5'd0, 5'd0, 32'hFFF0_0000);
        // Opcode 7'h7F is not RV32I
        w.raw = 32'h1234_567F;
        add_row(w.raw, FMT_BAD, 5'd0, 5'd0, 5'd0, 32'h0000_0000);

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeout_errors++;
            $display("Timeout: reset was never released");
        end

        expect_idle(10, "before start");

        // Memory image, plus a copy of row 0 in the top word
        foreach (rows[i]) begin
            load_word(addr_t'(4 * i), rows[i].word);
        end
        load_word(LAST_WORD, rows[0].word);
        @(negedge clk);
        load_en = 1'b0;

        // PC expected to step by 4 per taken item
        start_fetch('0);
        foreach (rows[i]) begin
            take_inst(ok);
            if (ok) begin
                verify_inst(rows[i], addr_t'(4 * i), $sformatf("row %0d", i));
            end
        end
        stop_and_drain();
        expect_idle(20, "after halt");

        // Top word is fine, the next one lies past the end
        start_fetch(LAST_WORD);
        take_inst(ok);
        if (ok) begin
            verify_inst(rows[0], LAST_WORD, "last word");
        end
        take_inst(ok);
        if (ok) begin
            verify_inst(illegal_row, LAST_WORD + addr_t'(4), "past end");
        end
        stop_and_drain();

        start_fetch(addr_t'(2));
        take_inst(ok);
        if (ok) begin
            verify_inst(illegal_row, addr_t'(2), "misaligned");
        end
        stop_and_drain();

        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: frontend.f
+incdir+.
riscv_pkg.sv
frontend_pkg.sv
imss_if.sv
fetch_pc_gen.sv
imss_stub.sv
inst_decode.sv
frontend_top.sv
tb_clkgen.sv
frontend_tb.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - .
    files:
      - riscv_pkg.sv
      - frontend_pkg.sv
      - imss_if.sv
      - fetch_pc_gen.sv
      - imss_stub.sv
      - inst_decode.sv
      - frontend_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - frontend_tb.sv
